/* sim.f */
hdl/rv_pkg.sv
hdl/bus_if.sv
hdl/sram.sv
hdl/bus_arbiter.sv
hdl/fetch_unit.sv
hdl/rv_core.sv
hdl/rv_soc.sv
verif/tb_rv_soc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_rv_soc -o tb_rv_soc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

/* verif/tb_rv_soc.sv */
module tb_rv_soc;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC    = 44;
    localparam logic [XLEN-1:0] TRAP_VECTOR = 0;
    localparam logic [XLEN-1:0] EXT_IRQ_CAUSE = 64'h8000_0000_0000_000b;  // Interrupt bit, code 11
    localparam int MEM_WORDS   = 1024;
    localparam int N_INSTR     = 120;               // Generated slots including the self-loop
    localparam int DATA_BASE   = 1024;              // Byte address of the LD/SD area
    localparam int DATA_WORDS  = 16;
    localparam int LOOP_HITS   = 8;                 // Self-loop retirements that end the run
    localparam int CYCLE_LIMIT = 40 * N_INSTR + 2000;

    logic            clk;
    logic            reset;
    logic            run;
    logic            prog_we;
    logic [XLEN-1:0] prog_addr;
    logic [XLEN-1:0] prog_wdata;
    logic            irq;
    logic            retire_valid;
    logic [XLEN-1:0] retire_pc;
    logic [4:0]      retire_rd;
    logic [XLEN-1:0] retire_value;
    logic            retire_trap;
    logic            store_valid;
    logic [XLEN-1:0] store_addr;
    logic [XLEN-1:0] store_data;

    logic [XLEN-1:0] image [MEM_WORDS];    // Loaded memory and later the model's copy
    opcode_e         kind  [2*MEM_WORDS];  // Decoded program with one entry per 4-byte slot
    logic [4:0]      f_rd  [2*MEM_WORDS];
    logic [4:0]      f_rs1 [2*MEM_WORDS];
    logic [4:0]      f_rs2 [2*MEM_WORDS];
    logic [XLEN-1:0] f_imm [2*MEM_WORDS];
    logic [XLEN-1:0] mregs [32];
    logic [XLEN-1:0] mpc;                  // Model pc of the next retirement
    logic [XLEN-1:0] mmepc;
    logic            mmie;
    logic            irq_seen;             // Irq level one cycle before the current sample
    logic [XLEN-1:0] last_pc;              // Self-loop
    logic [31:0]     seed = 32'habc0_5f6a;
    int              cycles;
    int              loop_hits;
    int              trap_count;

    rv_soc #(
        .RESET_PC    (RESET_PC),
        .TRAP_VECTOR (TRAP_VECTOR),
        .MEM_WORDS   (MEM_WORDS)
    ) u_dut (
        .clk, .reset, .run, .prog_we, .prog_addr, .prog_wdata, .irq,
        .retire_valid, .retire_pc, .retire_rd, .retire_value, .retire_trap,
        .store_valid, .store_addr, .store_data
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Uniform-ish value in 0..n-1
    function automatic int next_rand(input int n);
        seed = xorshift(seed);
        return int'(seed % 32'(n));
    endfunction

    function automatic logic [XLEN-1:0] reg_val(input logic [4:0] r);
        return (r == 5'd0) ? '0 : mregs[r];  // x0 always zero
    endfunction

    task automatic stop_on_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Places one encoded instruction and its decoded fields
    task automatic put_instr(input int slot, input logic [31:0] ins, input opcode_e k,
                             input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [XLEN-1:0] imm);
        if (slot % 2 == 1)
            image[slot/2][63:32] = ins;  // Upper half when pc bit 2 is set
        else
            image[slot/2][31:0] = ins;
        kind[slot]  = k;
        f_rd[slot]  = rd;
        f_rs1[slot] = rs1;
        f_rs2[slot] = rs2;
        f_imm[slot] = imm;
    endtask

    task automatic gen_program();
        int          slot;
        int          pick;
        int          skip;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [12:0] boff;
        for (int i = 0; i < MEM_WORDS; i++)
            image[i] = {32'(i) * 32'h9e37_79b1, 32'(i) ^ 32'h0f1e_2d3c};  // Per-word fill
        for (int i = 0; i < 2*MEM_WORDS; i++)
            kind[i] = ILLEGAL;
        // Handler bumps x31 and returns
        slot = int'(TRAP_VECTOR / 4);
        put_instr(slot, {12'd1, 5'd31, 3'b000, 5'd31, OP_IMM}, OP_IMM,
                  5'd31, 5'd31, 5'd0, 64'd1);
        put_instr(slot + 1, 32'h3020_0073, SYSTEM, 5'd0, 5'd0, 5'd0, 64'd0);  // MRET
        slot = int'(RESET_PC / 4);
        for (int k = 0; k < N_INSTR - 1; k++) begin
            rd    = 5'(next_rand(31));  // x31 stays with the handler
            rs1   = 5'(next_rand(31));
            rs2   = 5'(next_rand(31));
            imm12 = 12'(next_rand(4096));
            pick  = next_rand(10);
            if (pick < 2) begin
                imm20 = 20'(next_rand(1 << 20));
                put_instr(slot, {imm20, rd, LUI}, LUI, rd, 5'd0, 5'd0,
                          {{32{imm20[19]}}, imm20, 12'b0});
            end else if (pick < 4) begin
                put_instr(slot, {imm12, rs1, 3'b000, rd, OP_IMM}, OP_IMM, rd, rs1, 5'd0,
                          {{52{imm12[11]}}, imm12});
            end else if (pick < 6) begin
                put_instr(slot, {7'b0, rs2, rs1, 3'b000, rd, OP}, OP, rd, rs1, rs2, 64'd0);
            end else if (pick < 8) begin
                imm12 = 12'(DATA_BASE + 8 * next_rand(DATA_WORDS));  // Aligned off x0
                if (pick == 6)
                    put_instr(slot, {imm12, 5'd0, 3'b011, rd, LOAD}, LOAD, rd, 5'd0, 5'd0,
                              64'(imm12));
                else
                    put_instr(slot, {imm12[11:5], rs2, 5'd0, 3'b011, imm12[4:0], STORE},
                              STORE, 5'd0, 5'd0, rs2, 64'(imm12));
            end else begin
                skip = 1 + next_rand(3);
                if (k + skip + 1 > N_INSTR - 1)
                    skip = N_INSTR - 2 - k;  // Never past the self-loop
                if (pick == 8)
                    rs2 = rs1;               // Always taken
                boff = 13'(4 * (skip + 1));
                put_instr(slot, {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11],
                          BRANCH}, BRANCH, 5'd0, rs1, rs2, 64'(boff));
            end
            slot++;
        end
        put_instr(slot, {25'd0, BRANCH}, BRANCH, 5'd0, 5'd0, 5'd0, 64'd0);  // BEQ x0, x0, 0
        last_pc = XLEN'(slot * 4);
    endtask

    // One model step per retirement
    task automatic model_retire();
        int              idx;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] exp_val;
        logic [XLEN-1:0] npc;
        logic            has_val;
        check("retire_pc", mpc, retire_pc);
        if (retire_trap) begin
            check("trap_mie_set", 64'd1, XLEN'(mmie));  // None inside the handler
            check("trap_irq_high", 64'd1, XLEN'(irq_seen));
            check("trap_cause", EXT_IRQ_CAUSE, retire_value);
            check("trap_store", 64'd0, XLEN'(store_valid));
            mmepc = mpc;
            mmie  = 1'b0;
            mpc   = TRAP_VECTOR;
            trap_count++;
        end else begin
            if (mpc >= XLEN'(8 * MEM_WORDS) || kind[int'(mpc >> 2)] == ILLEGAL) begin
                $display("Retirement at pc %h, which holds no generated instruction", mpc);
                stop_on_failure();
            end
            idx     = int'(mpc >> 2);
            a       = reg_val(f_rs1[idx]);
            b       = reg_val(f_rs2[idx]);
            addr    = a + f_imm[idx];
            exp_val = '0;
            has_val = 1'b1;
            npc     = mpc + 4;
            case (kind[idx])
                LUI:    exp_val = f_imm[idx];
                OP_IMM: exp_val = a + f_imm[idx];
                OP:     exp_val = a + b;
                LOAD:   exp_val = image[addr[12:3]];
                STORE: begin
                    has_val = 1'b0;
                    check("store_valid", 64'd1, XLEN'(store_valid));
                    check("store_addr", addr, store_addr);
                    check("store_data", b, store_data);
                    image[addr[12:3]] = b;
                end
                BRANCH: begin
                    has_val = 1'b0;
                    if (a == b)
                        npc = mpc + f_imm[idx];  // Skipped slots must not retire
                    if (mpc == last_pc)
                        loop_hits++;
                end
                SYSTEM: begin
                    has_val = 1'b0;
                    npc     = mmepc;
                    mmie    = 1'b1;
                end
                default: ;
            endcase
            if (kind[idx] != STORE)
                check("store_valid", 64'd0, XLEN'(store_valid));
            check("retire_rd", XLEN'(f_rd[idx]), XLEN'(retire_rd));
            if (has_val)
                check("retire_value", exp_val, retire_value);
            if (has_val && f_rd[idx] != 5'd0)
                mregs[f_rd[idx]] = exp_val;
            mpc = npc;
        end
    endtask

    initial begin
        int irq_wait;
        reset      = 1'b0;
        run        = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_wdata = '0;
        irq        = 1'b0;
        gen_program();
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        mpc        = RESET_PC;
        mmepc      = '0;
        mmie       = 1'b1;
        irq_seen   = 1'b0;
        cycles     = 0;
        loop_hits  = 0;
        trap_count = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b1;
        // Whole memory through the loader port
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            prog_we    <= 1'b1;
            prog_addr  <= XLEN'(8 * i);
            prog_wdata <= image[i];
        end
        @(posedge clk);
        prog_we  <= 1'b0;
        run      <= 1'b1;
        irq_wait = 20 + next_rand(60);
        while (loop_hits < LOOP_HITS) begin
            @(posedge clk);
            if (irq_wait > 0) begin
                irq_wait--;
            end else begin
                irq      <= !irq;
                irq_wait = irq ? 20 + next_rand(60) : 1 + next_rand(40);  // Low gap or high hold
            end
            @(negedge clk);  // Outputs settled
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("Timeout after %0d cycles before the program reached its end", cycles);
                stop_on_failure();
            end
            if (retire_valid)
                model_retire();
            else
                check("store_without_retire", 64'd0, XLEN'(store_valid));
            irq_seen = irq;  // Level the core decides a trap on
        end
        check("irq_traps_taken", 64'd1, XLEN'(trap_count > 0));
        $display("All checks passed");
        $finish;
    end

endmodule

/* hdl/rv_soc.sv */
module rv_soc #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC    = 44,
    parameter logic [rv_pkg::XLEN-1:0] TRAP_VECTOR = '0,
    parameter int                      MEM_WORDS   = 2 ** rv_pkg::MEM_AW
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,
    input  logic                    prog_we,
    input  logic [rv_pkg::XLEN-1:0] prog_addr,   // Byte address
    input  logic [rv_pkg::XLEN-1:0] prog_wdata,
    input  logic                    irq,
    output logic                    retire_valid,
    output logic [rv_pkg::XLEN-1:0] retire_pc,
    output logic [4:0]              retire_rd,
    output logic [rv_pkg::XLEN-1:0] retire_value,
    output logic                    retire_trap,
    output logic                    store_valid,
    output logic [rv_pkg::XLEN-1:0] store_addr,
    output logic [rv_pkg::XLEN-1:0] store_data
);
    import rv_pkg::*;

    logic              instr_valid;
    logic [ILEN-1:0]   instr;
    logic [XLEN-1:0]   instr_pc;
    logic              instr_taken;
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;
    logic              mem_en;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_addr;
    logic [XLEN-1:0]   mem_wdata;
    logic [XLEN-1:0]   mem_rdata;

    bus_if ld_bus ();
    bus_if d_bus ();
    bus_if f_bus ();

    // Loader writes one doubleword per prog_we cycle
    assign ld_bus.req   = prog_we;
    assign ld_bus.we    = 1'b1;
    assign ld_bus.addr  = prog_addr;
    assign ld_bus.wdata = prog_wdata;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk, .reset, .run, .redirect, .redirect_pc,
        .instr_valid, .instr, .instr_pc, .instr_taken,
        .bus (f_bus)
    );

    rv_core #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) u_core (
        .clk, .reset, .irq,
        .instr_valid, .instr, .instr_pc,
        .instr_taken, .redirect, .redirect_pc,
        .dbus (d_bus),
        .retire_valid, .retire_pc, .retire_rd, .retire_value, .retire_trap,
        .store_valid, .store_addr, .store_data
    );

    bus_arbiter #(
        .MEM_WORDS (MEM_WORDS)
    ) u_arb (
        .clk, .reset,
        .ld_port (ld_bus),
        .d_port  (d_bus),
        .f_port  (f_bus),
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk,
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* hdl/rv_core.sv */
module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] TRAP_VECTOR = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    irq,
    input  logic                    instr_valid,
    input  logic [rv_pkg::ILEN-1:0] instr,
    input  logic [rv_pkg::XLEN-1:0] instr_pc,
    output logic                    instr_taken,
    output logic                    redirect,
    output logic [rv_pkg::XLEN-1:0] redirect_pc,
    bus_if.master                   dbus,
    output logic                    retire_valid,
    output logic [rv_pkg::XLEN-1:0] retire_pc,
    output logic [4:0]              retire_rd,
    output logic [rv_pkg::XLEN-1:0] retire_value,
    output logic                    retire_trap,
    output logic                    store_valid,
    output logic [rv_pkg::XLEN-1:0] store_addr,
    output logic [rv_pkg::XLEN-1:0] store_data
);
    import rv_pkg::*;

    localparam logic [XLEN-1:0] IRQ_CAUSE = {1'b1, {(XLEN-5){1'b0}}, 4'd11};  // Machine ext irq

    exec_state_e     state;
    logic [XLEN-1:0] regs [32];
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic            mie;        // mstatus.MIE
    logic            d_req;
    logic            d_we;
    logic [XLEN-1:0] d_addr;
    logic [XLEN-1:0] d_wdata;
    logic [XLEN-1:0] mem_pc;     // Pc of the LD/SD in progress
    logic [4:0]      mem_rd;
    opcode_e         opc;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            take_irq;

    assign opc = get_opcode(instr);
    assign rd  = get_rd(instr);
    assign rs1 = get_rs1(instr);
    assign rs2 = get_rs2(instr);
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads zero
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // Interrupts only at an instruction boundary
    assign take_irq    = (state == EXEC) && instr_valid && irq && mie;
    assign instr_taken = (state == EXEC) && instr_valid && !take_irq;

    always_comb begin
        redirect     = 1'b0;
        redirect_pc  = '0;
        retire_valid = 1'b0;
        retire_pc    = instr_pc;
        retire_rd    = 5'd0;
        retire_value = '0;
        retire_trap  = 1'b0;
        store_valid  = 1'b0;
        case (state)
            EXEC: begin
                if (instr_taken) begin
                    case (opc)
                        LUI: begin
                            retire_valid = 1'b1;
                            retire_rd    = rd;
                            retire_value = imm_u(instr);
                        end
                        OP_IMM: begin
                            retire_valid = 1'b1;
                            retire_rd    = rd;
                            retire_value = rs1_val + imm_i(instr);
                        end
                        OP: begin
                            retire_valid = 1'b1;
                            retire_rd    = rd;
                            retire_value = rs1_val + rs2_val;
                        end
                        BRANCH: begin
                            retire_valid = 1'b1;
                            redirect     = (rs1_val == rs2_val);  // Taken BEQ only
                            redirect_pc  = instr_pc + imm_b(instr);
                        end
                        SYSTEM: begin                              // MRET
                            retire_valid = 1'b1;
                            redirect     = 1'b1;
                            redirect_pc  = mepc;
                        end
                        LOAD, STORE: ;        // Retire from the wait states
                        default: retire_valid = 1'b1;  // Unknown is a no-op
                    endcase
                end
            end
            LOAD_WAIT: begin
                if (dbus.rvalid) begin
                    retire_valid = 1'b1;
                    retire_pc    = mem_pc;
                    retire_rd    = mem_rd;
                    retire_value = dbus.rdata;
                end
            end
            STORE_WAIT: begin
                if (dbus.gnt) begin
                    retire_valid = 1'b1;
                    retire_pc    = mem_pc;
                    store_valid  = 1'b1;
                end
            end
            TRAP: begin
                retire_valid = 1'b1;
                retire_trap  = 1'b1;
                retire_pc    = mepc;
                retire_value = mcause;  // Cause shows on the trap retirement
                redirect     = 1'b1;
                redirect_pc  = TRAP_VECTOR;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state  <= EXEC;
            mie    <= 1'b1;
            d_req  <= 1'b0;
            mepc   <= '0;
            mcause <= '0;
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else begin
            if (d_req && dbus.gnt)
                d_req <= 1'b0;
            if (retire_valid && !retire_trap && retire_rd != 5'd0)
                regs[retire_rd] <= retire_value;  // x0 never written
            case (state)
                EXEC: begin
                    if (take_irq) begin
                        mepc   <= instr_pc;  // Not retired, resumes here
                        mcause <= IRQ_CAUSE;
                        mie    <= 1'b0;
                        state  <= TRAP;
                    end else if (instr_taken) begin
                        if (opc == LOAD) begin
                            d_req <= 1'b1;
                            state <= LOAD_WAIT;
                        end else if (opc == STORE) begin
                            d_req <= 1'b1;
                            state <= STORE_WAIT;
                        end else if (opc == SYSTEM) begin
                            mie <= 1'b1;     // MRET re-enables
                        end
                    end
                end
                LOAD_WAIT:  if (dbus.rvalid) state <= EXEC;
                STORE_WAIT: if (dbus.gnt) state <= EXEC;
                TRAP:       state <= EXEC;
                default:    state <= EXEC;
            endcase
        end
    end

    // Memory op fields, captured when the LD/SD is taken
    always_ff @(posedge clk) begin
        if (instr_taken && (opc == LOAD || opc == STORE)) begin
            d_we    <= (opc == STORE);
            d_addr  <= rs1_val + ((opc == STORE) ? imm_s(instr) : imm_i(instr));
            d_wdata <= rs2_val;
            mem_pc  <= instr_pc;
            mem_rd  <= (opc == LOAD) ? rd : 5'd0;
        end
    end

    assign dbus.req   = d_req;
    assign dbus.we    = d_we;
    assign dbus.addr  = d_addr;
    assign dbus.wdata = d_wdata;

    assign store_addr = d_addr;
    assign store_data = d_wdata;

endmodule

/* hdl/fetch_unit.sv */
module fetch_unit #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = 44
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,
    input  logic                    redirect,
    input  logic [rv_pkg::XLEN-1:0] redirect_pc,
    output logic                    instr_valid,
    output logic [rv_pkg::ILEN-1:0] instr,
    output logic [rv_pkg::XLEN-1:0] instr_pc,
    input  logic                    instr_taken,
    bus_if.master                   bus
);
    import rv_pkg::*;

    logic [XLEN-1:0] fetch_pc;   // Next pc to request
    logic [XLEN-1:0] start_pc;
    logic [XLEN-1:0] req_pc;     // Pc of the held request
    logic [XLEN-1:0] pend_pc;    // Pc of the granted read
    logic [XLEN-1:0] buf_pc;
    logic [ILEN-1:0] buf_instr;
    logic            req_q;
    logic            pend_q;     // Read granted, data next cycle
    logic            stale_q;    // Outstanding read belongs to the old path
    logic            buf_valid;
    logic            start;
    logic            fill;

    assign start_pc = redirect ? redirect_pc : fetch_pc;
    // New request only once the buffer is free by the time data returns
    assign start = run && !req_q && !pend_q && (!buf_valid || instr_taken || redirect);
    assign fill  = pend_q && bus.rvalid && !stale_q && !redirect;  // Redirect drops it

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fetch_pc  <= RESET_PC;
            req_q     <= 1'b0;
            pend_q    <= 1'b0;
            stale_q   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (start) begin
                req_q    <= 1'b1;
                fetch_pc <= start_pc + 4;
            end else begin
                if (redirect)
                    fetch_pc <= redirect_pc;
                if (req_q && bus.gnt)
                    req_q <= 1'b0;
            end
            pend_q <= req_q && bus.gnt;
            if (pend_q && bus.rvalid)
                stale_q <= 1'b0;
            if (redirect && req_q)
                stale_q <= 1'b1;   // Held request now wrong path
            if (fill)
                buf_valid <= 1'b1;
            else if (instr_taken || redirect)
                buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            req_pc <= start_pc;
        if (req_q && bus.gnt)
            pend_pc <= req_pc;
        if (fill) begin
            buf_pc    <= pend_pc;
            // Pc bit 2 picks the upper instruction
            buf_instr <= pend_pc[2] ? bus.rdata[XLEN-1:ILEN] : bus.rdata[ILEN-1:0];
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = 1'b0;
    assign bus.addr  = req_pc;
    assign bus.wdata = '0;

    assign instr_valid = buf_valid;
    assign instr       = buf_instr;
    assign instr_pc    = buf_pc;

endmodule

/* hdl/bus_arbiter.sv */
module bus_arbiter #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                      clk,
    input  logic                      reset,
    bus_if.slave                      ld_port,   // Loader, highest priority
    bus_if.slave                      d_port,    // Core load/store
    bus_if.slave                      f_port,    // Fetch, lowest
    output logic                      mem_en,
    output logic                      mem_we,
    output logic [rv_pkg::MEM_AW-1:0] mem_addr,
    output logic [rv_pkg::XLEN-1:0]   mem_wdata,
    input  logic [rv_pkg::XLEN-1:0]   mem_rdata
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);  // Word index bits actually used

    logic [XLEN-1:0] sel_addr;
    logic [2:0]      rd_owner;  // One-hot, {fetch, data, loader}

    // Fixed priority grants
    assign ld_port.gnt = ld_port.req;
    assign d_port.gnt  = d_port.req && !ld_port.req;
    assign f_port.gnt  = f_port.req && !ld_port.req && !d_port.req;

    always_comb begin
        mem_en    = 1'b1;
        mem_we    = 1'b0;
        sel_addr  = '0;
        mem_wdata = '0;
        if (ld_port.req) begin
            mem_we    = ld_port.we;
            sel_addr  = ld_port.addr;
            mem_wdata = ld_port.wdata;
        end else if (d_port.req) begin
            mem_we    = d_port.we;
            sel_addr  = d_port.addr;
            mem_wdata = d_port.wdata;
        end else if (f_port.req) begin
            sel_addr  = f_port.addr;   // Fetch only reads
            mem_wdata = f_port.wdata;
            mem_we    = f_port.we;
        end else begin
            mem_en = 1'b0;             // Idle
        end
    end

    // Byte to doubleword address
    assign mem_addr = MEM_AW'(sel_addr[3 +: IDX_W]);

    // Remember who owns the read in flight
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            rd_owner <= 3'b000;
        else
            rd_owner <= {f_port.gnt && !f_port.we,
                         d_port.gnt && !d_port.we,
                         ld_port.gnt && !ld_port.we};
    end

    assign ld_port.rvalid = rd_owner[0];
    assign d_port.rvalid  = rd_owner[1];
    assign f_port.rvalid  = rd_owner[2];

    // Data fans out, rvalid picks the owner
    assign ld_port.rdata = mem_rdata;
    assign d_port.rdata  = mem_rdata;
    assign f_port.rdata  = mem_rdata;

endmodule

/* hdl/sram.sv */
module sram #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                      clk,
    input  logic                      en,
    input  logic                      we,
    input  logic [rv_pkg::MEM_AW-1:0] addr,   // Word address
    input  logic [rv_pkg::XLEN-1:0]   wdata,
    output logic [rv_pkg::XLEN-1:0]   rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [MEM_WORDS];

    // Write at the edge, read data lands next cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we)
                mem[addr] <= wdata;
            else
                rdata <= mem[addr];  // Held until next read
        end
    end

endmodule

/* hdl/bus_if.sv */
interface bus_if;
    import rv_pkg::*;

    logic            req;     // Held until gnt
    logic            we;
    logic [XLEN-1:0] addr;    // Byte address
    logic [XLEN-1:0] wdata;
    logic            gnt;     // Transfer cycle
    logic            rvalid;  // One cycle after a read grant
    logic [XLEN-1:0] rdata;

    modport master (
        output req, we, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport slave (
        input  req, we, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

/* hdl/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN   = 64;  // Data width
    localparam int ILEN   = 32;  // Instruction width
    localparam int MEM_AW = 10;  // Doubleword address bits, 1024 words

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        OP_IMM  = 7'b0010011,  // ADDI
        OP      = 7'b0110011,  // ADD
        LOAD    = 7'b0000011,  // LD
        STORE   = 7'b0100011,  // SD
        BRANCH  = 7'b1100011,  // BEQ
        SYSTEM  = 7'b1110011,  // MRET
        ILLEGAL = 7'b0000000
    } opcode_e;

    // Core execute states
    typedef enum logic [1:0] {
        EXEC,
        LOAD_WAIT,
        STORE_WAIT,
        TRAP
    } exec_state_e;

    // Unknown encodings fold to ILLEGAL
    function automatic opcode_e get_opcode(input logic [ILEN-1:0] ins);
        case (ins[6:0])
            LUI, OP_IMM, OP, LOAD, STORE, BRANCH, SYSTEM: return opcode_e'(ins[6:0]);
            default: return ILLEGAL;
        endcase
    endfunction

    function automatic logic [4:0] get_rd(input logic [ILEN-1:0] ins);
        return ins[11:7];
    endfunction

    function automatic logic [4:0] get_rs1(input logic [ILEN-1:0] ins);
        return ins[19:15];
    endfunction

    function automatic logic [4:0] get_rs2(input logic [ILEN-1:0] ins);
        return ins[24:20];
    endfunction

    // Sign-extended immediates
    function automatic logic [XLEN-1:0] imm_i(input logic [ILEN-1:0] ins);
        return {{(XLEN-12){ins[31]}}, ins[31:20]};
    endfunction

    function automatic logic [XLEN-1:0] imm_s(input logic [ILEN-1:0] ins);
        return {{(XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
    endfunction

    function automatic logic [XLEN-1:0] imm_b(input logic [ILEN-1:0] ins);
        return {{(XLEN-13){ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_u(input logic [ILEN-1:0] ins);
        return {{(XLEN-32){ins[31]}}, ins[31:12], 12'b0};
    endfunction

endpackage
